/* list.f */
+incdir+hdl
hdl/qsic_pkg.sv
hdl/slot_bus_if.sv
hdl/qbus_reply.sv
hdl/csr_decode.sv
hdl/pack_slot.sv
hdl/pack_select.sv
hdl/qsic_top.sv
sim/qsic_props.sv
sim/qsic_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= qsic_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/qsic_tb.sv */
`include "qsic_settings.svh"

module qsic_tb;
   import qsic_pkg::*;

   localparam int reply_timeout = 20;
   localparam logic [12:0] test_off = 13'o17720;

   logic                       clk20;
   logic                       arst_n;
   logic [`QSIC_DAL_W-1:0]     dal_in;
   logic                       bs7_in;
   logic                       wtbt_in;
   logic                       rsync;
   logic                       rdin;
   logic                       rdout;
   logic [`QSIC_DAL_W-1:0]     dal_out;
   logic                       dal_tx;
   logic                       dal_st;
   logic                       dal_be_l;
   logic                       trply;
   logic [2:0]                 drive_sel;
   logic [`QSIC_RK_LBA_W-1:0]  rk_lba;
   logic [`QSIC_NUM_DEVS-1:0]  dev_ready;
   logic [`QSIC_LBA_W-1:0]     lba;
   storage_dev_e               sd_select;
   logic [`QSIC_NUM_PACKS-1:0] loaded;

   // reference copy of every register
   logic [15:0] model_slot [8];
   logic [15:0] model_test;
   int          mismatches;
   int          failures;

   qsic_top dut (.*);

   bind qbus_reply qsic_props u_props (
      .clk20(clk20), .arst_n(arst_n), .match(match), .trply(trply),
      .wr_pulse(wr_pulse), .dal_tx(dal_tx), .dal_st(dal_st), .dal_be_l(dal_be_l)
   );

   initial begin
      clk20 = 1'b0;
      forever #20 clk20 = ~clk20;
   end

   // registered outputs are settled 2 units after the edge, inputs change there too
   task automatic next_cycle();
      @(posedge clk20);
      #2;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      mismatches++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
   endtask

   task automatic report_failure(input string what);
      failures++;
      $display("error: %s", what);
   endtask

   // index 8 is the test register, 0..7 the load table words
   function automatic logic [12:0] reg_offset(input int idx);
      return (idx == 8) ? test_off : 13'(13'o17700 + 2 * idx);
   endfunction

   function automatic logic [15:0] model_word(input int idx);
      return (idx == 8) ? model_test : model_slot[idx];
   endfunction

   // one full qbus cycle, address held four cycles before the data strobe
   task automatic bus_cycle(input logic [12:0] offset, input logic bs7, input logic write,
                            input logic [15:0] wdata, input logic expect_reply,
                            output logic [15:0] rdata);
      int   n;
      logic tx_early;
      rdata    = '0;
      tx_early = 1'b0;
      dal_in   = {9'h1ff, offset};
      bs7_in   = bs7;
      wtbt_in  = write;
      rsync    = 1'b1;
      repeat (4) next_cycle();
      bs7_in = 1'b0;
      if (write) begin
         dal_in = {6'h00, wdata};
         rdout  = 1'b1;
      end else begin
         dal_in = '0;
         rdin   = 1'b1;
      end
      n = 0;
      while (!trply && n < reply_timeout) begin
         next_cycle();
         // transceivers must turn before the reply
         if (dal_tx && !trply) begin
            tx_early = 1'b1;
         end
         n++;
      end
      if (!expect_reply && trply) begin
         report_failure($sformatf("trply raised for unmapped offset %o", offset));
      end else if (expect_reply && !trply) begin
         report_failure($sformatf("timeout waiting for trply to rise, offset %o", offset));
      end else if (expect_reply && !write) begin
         if (!tx_early || !dal_st || dal_be_l) begin
            report_failure("read reply without dal_tx first, dal_st high, dal_be_l low");
         end
         if (dal_out[21:16] != 6'd0) begin
            report_failure("upper dal_out bits not zero on read");
         end
         rdata = dal_out[15:0];
      end
      rdin  = 1'b0;
      rdout = 1'b0;
      n = 0;
      while (trply && n < reply_timeout) begin
         next_cycle();
         n++;
      end
      if (trply) begin
         report_failure("timeout waiting for trply to fall");
      end
      if (dal_tx || dal_st || !dal_be_l) begin
         report_failure("transceiver controls still active after the cycle");
      end
      rsync   = 1'b0;
      dal_in  = '0;
      wtbt_in = 1'b0;
      // let match clear before the next address phase
      repeat (4) next_cycle();
   endtask

   task automatic read_all(input string name);
      logic [15:0] rd;
      int          idx;
      for (idx = 0; idx < 9; idx++) begin
         bus_cycle(reg_offset(idx), 1'b1, 1'b0, 16'h0, 1'b1, rd);
         if (rd !== model_word(idx)) begin
            report_mismatch($sformatf("%s reg %0d", name, idx), 32'(model_word(idx)), 32'(rd));
         end
      end
   endtask

   // random drive side inputs against the table rule
   task automatic check_select();
      logic [15:0] w;
      logic [31:0] exp_lba;
      logic [7:0]  exp_loaded;
      int          i;
      drive_sel = 3'($urandom);
      rk_lba    = 13'($urandom);
      dev_ready = 4'($urandom);
      #1;
      // loaded needs the enable bit and its device ready
      for (i = 0; i < 8; i++) begin
         exp_loaded[i] = model_slot[i][15] & dev_ready[model_slot[i][14:13]];
      end
      w       = model_slot[drive_sel];
      exp_lba = {19'd0, rk_lba} + {6'd0, w[12:0], 13'd0};
      if (lba !== exp_lba) begin
         report_mismatch("select lba", exp_lba, lba);
      end
      if (2'(sd_select) !== w[14:13]) begin
         report_mismatch("select device", 32'(w[14:13]), 32'(2'(sd_select)));
      end
      if (loaded !== exp_loaded) begin
         report_mismatch("select loaded", 32'(exp_loaded), 32'(loaded));
      end
      next_cycle();
   endtask

   initial begin
      logic [15:0] rd;
      logic [15:0] wd;
      int          idx;
      int          i;
      void'($urandom(32'h4519));
      mismatches = 0;
      failures   = 0;
      arst_n     = 1'b0;
      dal_in     = '0;
      bs7_in     = 1'b0;
      wtbt_in    = 1'b0;
      rsync      = 1'b0;
      rdin       = 1'b0;
      rdout      = 1'b0;
      drive_sel  = '0;
      rk_lba     = '0;
      dev_ready  = '0;
      // power-up table: slot 0 on sd0 at 16, slot 1 on ramdisk, rest off
      model_slot[0] = 16'h8010;
      model_slot[1] = 16'hc000;
      for (i = 2; i < 8; i++) begin
         model_slot[i] = 16'(16 + i);
      end
      model_test = 16'hffff;
      repeat (8) @(posedge clk20);
      #2 arst_n = 1'b1;
      next_cycle();
      if (trply || dal_tx || dal_st || !dal_be_l) begin
         report_failure("reply outputs not idle after reset");
      end
      read_all("reset");
      repeat (10) check_select();
      // write then read back, test register and table words
      repeat (40) begin
         idx = int'($urandom % 9);
         wd  = 16'($urandom);
         bus_cycle(reg_offset(idx), 1'b1, 1'b1, wd, 1'b1, rd);
         if (idx == 8) begin
            model_test = wd;
         end else begin
            model_slot[idx] = wd;
         end
         bus_cycle(reg_offset(idx), 1'b1, 1'b0, 16'h0, 1'b1, rd);
         if (rd !== model_word(idx)) begin
            report_mismatch($sformatf("readback reg %0d", idx), 32'(model_word(idx)), 32'(rd));
         end
         check_select();
      end
      // bs7 low on a mapped offset, then offsets around the table
      repeat (10) begin
         idx = int'($urandom % 9);
         bus_cycle(reg_offset(idx), 1'b0, 1'b1, 16'($urandom), 1'b0, rd);
         bus_cycle(13'(13'o17722 + 2 * ($urandom % 16)), 1'b1, 1'b1, 16'($urandom), 1'b0, rd);
         bus_cycle(13'(13'o17600 + 2 * ($urandom % 32)), 1'b1, 1'b0, 16'h0, 1'b0, rd);
      end
      read_all("unmapped");
      repeat (10) check_select();
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* sim/qsic_props.sv */
module qsic_props (
   input logic clk20,
   input logic arst_n,
   input logic match,
   input logic trply,
   input logic wr_pulse,
   input logic dal_tx,
   input logic dal_st,
   input logic dal_be_l
);

   // data strobe only while the transceivers face the bus
   st_needs_tx: assert property (@(posedge clk20) disable iff (!arst_n) dal_st |-> dal_tx)
      else $error("dal_st high while dal_tx low");

   // drivers enabled only with the latch strobe up
   be_needs_st: assert property (@(posedge clk20) disable iff (!arst_n) !dal_be_l |-> dal_st)
      else $error("dal_be_l low while dal_st low");

   // a reply only for an address that hit one of the registers
   reply_needs_match: assert property (@(posedge clk20) disable iff (!arst_n)
      $rose(trply) |-> match)
      else $error("trply rose without a register match");

   // write strobe is a single cycle
   wr_pulse_single: assert property (@(posedge clk20) disable iff (!arst_n)
      wr_pulse |=> !wr_pulse)
      else $error("wr_pulse longer than one cycle");

endmodule

/* hdl/qsic_top.sv */
`include "qsic_settings.svh"

module qsic_top (
   input  logic                       clk20,
   input  logic                       arst_n,
   // qbus slave side
   input  logic [`QSIC_DAL_W-1:0]     dal_in,
   input  logic                       bs7_in,
   input  logic                       wtbt_in,
   input  logic                       rsync,
   input  logic                       rdin,
   input  logic                       rdout,
   output logic [`QSIC_DAL_W-1:0]     dal_out,
   output logic                       dal_tx,
   output logic                       dal_st,
   output logic                       dal_be_l,
   output logic                       trply,
   // rk controller and storage side
   input  logic [2:0]                 drive_sel,
   input  logic [`QSIC_RK_LBA_W-1:0]  rk_lba,
   input  logic [`QSIC_NUM_DEVS-1:0]  dev_ready,
   output logic [`QSIC_LBA_W-1:0]     lba,
   output qsic_pkg::storage_dev_e     sd_select,
   output logic [`QSIC_NUM_PACKS-1:0] loaded
);

   logic rsync_s;
   logic match;
   logic wr_pulse;

   // one bus per load table slot
   slot_bus_if slot_bus [`QSIC_NUM_PACKS] ();

   qbus_reply u_reply (
      .clk20    (clk20),
      .arst_n   (arst_n),
      .rsync    (rsync),
      .rdin     (rdin),
      .rdout    (rdout),
      .match    (match),
      .rsync_s  (rsync_s),
      .wr_pulse (wr_pulse),
      .trply    (trply),
      .dal_tx   (dal_tx),
      .dal_st   (dal_st),
      .dal_be_l (dal_be_l)
   );

   csr_decode u_decode (
      .clk20    (clk20),
      .arst_n   (arst_n),
      .dal_in   (dal_in),
      .bs7_in   (bs7_in),
      .wtbt_in  (wtbt_in),
      .rsync_s  (rsync_s),
      .wr_pulse (wr_pulse),
      .match    (match),
      .dal_out  (dal_out),
      .slots    (slot_bus)
   );

   for (genvar g = 0; g < `QSIC_NUM_PACKS; g++) begin : g_pack
      pack_slot #(.index(g)) u_slot (
         .clk20     (clk20),
         .arst_n    (arst_n),
         .dev_ready (dev_ready),
         .bus       (slot_bus[g])
      );
   end

   pack_select u_select (
      .drive_sel (drive_sel),
      .rk_lba    (rk_lba),
      .slots     (slot_bus),
      .lba       (lba),
      .sd_select (sd_select),
      .loaded    (loaded)
   );

endmodule

/* hdl/pack_select.sv */
`include "qsic_settings.svh"

module pack_select (
   input  logic [2:0]                  drive_sel,
   input  logic [`QSIC_RK_LBA_W-1:0]   rk_lba,
   slot_bus_if.sel                     slots [`QSIC_NUM_PACKS],
   output logic [`QSIC_LBA_W-1:0]      lba,
   output qsic_pkg::storage_dev_e      sd_select,
   output logic [`QSIC_NUM_PACKS-1:0]  loaded
);
   import qsic_pkg::*;

   pack_entry_t entries [`QSIC_NUM_PACKS];
   pack_entry_t cur;

   // interface arrays need constant indices, copy out first
   for (genvar g = 0; g < `QSIC_NUM_PACKS; g++) begin : g_gather
      assign entries[g] = slots[g].entry;
      assign loaded[g]  = slots[g].loaded;
   end

   // entry for the drive the controller is talking to
   assign cur = entries[drive_sel];

   assign sd_select = cur.dev;

   // pack base plus block within the pack
   assign lba = `QSIC_LBA_W'(rk_lba) + (`QSIC_LBA_W'(cur.offset) << `QSIC_OFFSET_SHIFT);

endmodule

/* hdl/pack_slot.sv */
`include "qsic_settings.svh"

module pack_slot #(
   parameter int unsigned index = 0
) (
   input  logic                       clk20,
   input  logic                       arst_n,
   input  logic [`QSIC_NUM_DEVS-1:0] dev_ready,
   slot_bus_if.slot                   bus
);
   import qsic_pkg::*;

   // power-up contents depend on slot position
   localparam pack_entry_t reset_entry = pack_reset_entry(index);

   always_ff @(posedge clk20 or negedge arst_n) begin
      if (!arst_n) begin
         bus.entry <= reset_entry;
      end else if (bus.wr) begin
         // raw bus word, field layout is the struct
         bus.entry <= pack_entry_t'(bus.wdata);
      end
   end

   // pack is usable once enabled and its device is up
   assign bus.loaded = bus.entry.enable & dev_ready[bus.entry.dev];

endmodule

/* hdl/csr_decode.sv */
`include "qsic_settings.svh"

module csr_decode (
   input  logic                   clk20,
   input  logic                   arst_n,
   input  logic [`QSIC_DAL_W-1:0] dal_in,
   input  logic                   bs7_in,
   input  logic                   wtbt_in,
   input  logic                   rsync_s,
   input  logic                   wr_pulse,
   output logic                   match,
   output logic [`QSIC_DAL_W-1:0] dal_out,
   slot_bus_if.ctrl               slots [`QSIC_NUM_PACKS]
);
   import qsic_pkg::*;

   localparam logic [`QSIC_IO_ADDR_W-1:0] table_base = `QSIC_TABLE_BASE;

   // delayed rsync_s, marks the capture cycle
   logic                       rsync_d;
   logic [`QSIC_IO_ADDR_W-1:0] io_addr;
   logic                       bs7_q;
   logic                       read_cycle;
   logic [`QSIC_DATA_W-1:0]    test_reg;
   pack_entry_t                entries [`QSIC_NUM_PACKS];
   logic                       test_hit;
   logic                       table_hit;
   logic [2:0]                 slot_idx;
   logic [`QSIC_DATA_W-1:0]    rdata;
   logic                       wr_en;

   // address phase, grab on the first cycle of synced sync
   always_ff @(posedge clk20 or negedge arst_n) begin
      if (!arst_n) begin
         rsync_d    <= 1'b0;
         io_addr    <= '0;
         bs7_q      <= 1'b0;
         read_cycle <= 1'b0;
         match      <= 1'b0;
      end else begin
         rsync_d <= rsync_s;
         if (rsync_s && !rsync_d) begin
            io_addr    <= dal_in[`QSIC_IO_ADDR_W-1:0];
            bs7_q      <= bs7_in;
            read_cycle <= ~wtbt_in;
         end
         // rsync_d keeps the stale address out of the capture cycle
         match <= rsync_s & rsync_d & (test_hit | table_hit);
      end
   end

   // i/o page decode, word addresses only
   assign test_hit  = bs7_q && (io_addr == `QSIC_TEST_REG_ADDR);
   assign table_hit = bs7_q && (io_addr[`QSIC_IO_ADDR_W-1:4] == table_base[`QSIC_IO_ADDR_W-1:4])
                      && !io_addr[0];
   assign slot_idx  = io_addr[3:1];

   // data is on dal_in when synced dout rises
   assign wr_en = wr_pulse & match & ~read_cycle;

   always_ff @(posedge clk20 or negedge arst_n) begin
      if (!arst_n) begin
         test_reg <= '1;
      end else if (wr_en && test_hit) begin
         test_reg <= dal_in[`QSIC_DATA_W-1:0];
      end
   end

   // fan the strobe out to the addressed slot
   for (genvar g = 0; g < `QSIC_NUM_PACKS; g++) begin : g_slot
      assign slots[g].wr    = wr_en && table_hit && (slot_idx == 3'(g));
      assign slots[g].wdata = dal_in[`QSIC_DATA_W-1:0];
      assign entries[g]     = slots[g].entry;
   end

   assign rdata   = test_hit ? test_reg : entries[slot_idx];
   // bus data is zero unless one of our registers is addressed
   assign dal_out = match ? `QSIC_DAL_W'(rdata) : '0;

endmodule

/* hdl/qbus_reply.sv */
module qbus_reply (
   input  logic clk20,
   input  logic arst_n,
   input  logic rsync,
   input  logic rdin,
   input  logic rdout,
   input  logic match,
   output logic rsync_s,
   output logic wr_pulse,
   output logic trply,
   output logic dal_tx,
   output logic dal_st,
   output logic dal_be_l
);
   import qsic_pkg::*;

   // two flop synchronizers, dout has a third stage for edge detect
   logic [1:0] rsync_ff;
   logic [1:0] din_ff;
   logic [2:0] dout_ff;
   logic       din_s;
   logic       dout_s;

   reply_state_e state;
   reply_state_e state_nxt;

   always_ff @(posedge clk20 or negedge arst_n) begin
      if (!arst_n) begin
         rsync_ff <= '0;
         din_ff   <= '0;
         dout_ff  <= '0;
      end else begin
         rsync_ff <= {rsync_ff[0], rsync};
         din_ff   <= {din_ff[0], rdin};
         dout_ff  <= {dout_ff[1:0], rdout};
      end
   end

   assign rsync_s = rsync_ff[1];
   assign din_s   = din_ff[1];
   assign dout_s  = dout_ff[1];

   // single cycle on the rising edge of synced dout
   assign wr_pulse = dout_ff[1] & ~dout_ff[2];

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            // read wins if both strobes show up
            if (match && din_s) begin
               state_nxt = READ_SETTLE1;
            end else if (match && dout_s) begin
               state_nxt = WRITE_REPLY;
            end
         end
         // two cycles of drive before reply, cable settling
         READ_SETTLE1: state_nxt = din_s ? READ_SETTLE2 : IDLE;
         READ_SETTLE2: state_nxt = din_s ? READ_REPLY : IDLE;
         // hold until the master drops its strobe
         READ_REPLY:   state_nxt = din_s ? READ_REPLY : IDLE;
         WRITE_REPLY:  state_nxt = dout_s ? WRITE_REPLY : IDLE;
         default:      state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk20 or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // transceivers turn toward the bus for the whole read
   assign dal_tx = (state == READ_SETTLE1) || (state == READ_SETTLE2) ||
                   (state == READ_REPLY);
   // latch and enable only once data has settled
   assign dal_st   = (state == READ_REPLY);
   assign dal_be_l = (state != READ_REPLY);
   assign trply    = (state == READ_REPLY) || (state == WRITE_REPLY);

endmodule

/* hdl/slot_bus_if.sv */
`include "qsic_settings.svh"

interface slot_bus_if;
   import qsic_pkg::*;

   // write strobe, one clk20 cycle
   logic                     wr;
   logic [`QSIC_DATA_W-1:0] wdata;
   // stored slot word
   pack_entry_t              entry;
   // enabled and its device is ready
   logic                     loaded;

   modport ctrl (output wr, output wdata, input entry);
   modport slot (input wr, input wdata, output entry, output loaded);
   modport sel  (input entry, input loaded);

endinterface

/* hdl/qsic_pkg.sv */
`include "qsic_settings.svh"

package qsic_pkg;

   // storage device codes as used by the storage multiplexer
   typedef enum logic [1:0] {
      SD0     = 2'd0,
      SD1     = 2'd1,
      RAMDISK = 2'd2,
      USB     = 2'd3
   } storage_dev_e;

   // slave reply sequencer
   typedef enum logic [2:0] {
      IDLE,
      READ_SETTLE1,
      READ_SETTLE2,
      READ_REPLY,
      WRITE_REPLY
   } reply_state_e;

   // enable and device take the top three bits of the word
   localparam int pack_offset_w = `QSIC_DATA_W - 3;

   // one load table word as seen on the bus
   typedef struct packed {
      logic                     enable;
      storage_dev_e             dev;
      logic [pack_offset_w-1:0] offset;
   } pack_entry_t;

   // power-up table with the sd0 pack in slot 0 and the ramdisk in slot 1
   // remaining slots stay parked on sd0
   function automatic pack_entry_t pack_reset_entry(input int unsigned idx);
      pack_entry_t e;
      e.enable = (idx < 2);
      e.dev    = (idx == 1) ? RAMDISK : SD0;
      // ramdisk starts at block zero, sd0 slots at 16 plus the slot index
      if (idx == 1) begin
         e.offset = '0;
      end else begin
         e.offset = pack_offset_w'(16 + idx);
      end
      return e;
   endfunction

endpackage

/* hdl/qsic_settings.svh */
`ifndef QSIC_SETTINGS_SVH
`define QSIC_SETTINGS_SVH

// qbus data/address lines
`define QSIC_DAL_W 22

// width of every slave register
`define QSIC_DATA_W 16

// drive load table size, one slot per rk drive
`define QSIC_NUM_PACKS 8

// storage devices behind the table
`define QSIC_NUM_DEVS 4

// i/o page offsets are decoded on the low 13 address bits
`define QSIC_IO_ADDR_W 13

// test register offset in the i/o page
`define QSIC_TEST_REG_ADDR 13'o17720

// first load table word, eight words up to 17716
`define QSIC_TABLE_BASE 13'o17700

// slot offsets count in 8192-block units
`define QSIC_OFFSET_SHIFT 13

// storage side block address
`define QSIC_LBA_W 32

// rk block address from the controller
`define QSIC_RK_LBA_W 13

`endif
